// ==== verilog/ex_defs.svh ====
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// Datapath word width
`define EX_XLEN 32

// Register index width, rs1/rs2/rd fields
`define EX_REG_W 5

// Instruction word width
`define EX_INST_W 32

// x0 is hardwired, never a forwarding source
`define EX_REG_ZERO 5'd0

`endif

// ==== verilog/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    // Opcode bits [6:2], low two bits are always 2'b11
    typedef enum logic [4:0] {
        OP_LOAD   = 5'b00000,
        OP_ITYPE  = 5'b00100,
        OP_AUIPC  = 5'b00101,
        OP_STORE  = 5'b01000,
        OP_RTYPE  = 5'b01100,
        OP_LUI    = 5'b01101,
        OP_BRANCH = 5'b11000,
        OP_JALR   = 5'b11001,
        OP_JAL    = 5'b11011,
        OP_SYSTEM = 5'b11100
    } opcode_e;

    // ALU funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Load and store funct3
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;

    // SYSTEM funct3, zero is ECALL/EBREAK
    localparam logic [2:0] F3_PRIV   = 3'b000;
    localparam logic [2:0] F3_CSRRW  = 3'b001;
    localparam logic [2:0] F3_CSRRS  = 3'b010;
    localparam logic [2:0] F3_CSRRC  = 3'b011;
    localparam logic [2:0] F3_CSRRWI = 3'b101;
    localparam logic [2:0] F3_CSRRSI = 3'b110;
    localparam logic [2:0] F3_CSRRCI = 3'b111;

    function automatic logic writes_rd(input opcode_e op);
        case (op)
            OP_RTYPE, OP_ITYPE, OP_LOAD, OP_JAL, OP_JALR,
            OP_LUI, OP_AUIPC, OP_SYSTEM: return 1'b1;
            default:                      return 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== verilog/ex_ctrl_pkg.sv ====
`default_nettype none

package ex_ctrl_pkg;

    // ALU operand A source
    typedef enum logic {
        A_REG = 1'b0,
        A_PC  = 1'b1
    } asel_e;

    // ALU operand B source
    typedef enum logic {
        B_REG = 1'b0,
        B_IMM = 1'b1
    } bsel_e;

    // Operand bypass source, MEM wins over WB
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwd_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_SLT    = 4'd8,
        ALU_PASS_B = 4'd9
    } alu_op_e;

endpackage

`default_nettype wire

// ==== verilog/ex_ctrl_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface ex_ctrl_if;

    ex_ctrl_pkg::asel_e   asel;
    ex_ctrl_pkg::bsel_e   bsel;
    ex_ctrl_pkg::alu_op_e alusel;
    // Unsigned compare for SLTU and unsigned branches
    logic                 brun;
    ex_ctrl_pkg::fwd_e    fwda;
    ex_ctrl_pkg::fwd_e    fwdb;
    // CSR write data from zimm instead of rs1
    logic                 csrwsel;
    logic                 csren;

    modport ctrl (output asel, bsel, alusel, brun, fwda, fwdb, csrwsel, csren);

    modport dp (input asel, bsel, alusel, brun, fwda, fwdb, csrwsel, csren);

endinterface

`default_nettype wire

// ==== verilog/ex_control.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ex_defs.svh"

module ex_control (
    input  logic [`EX_INST_W-1:0] inst,
    input  logic [`EX_INST_W-1:0] mem_inst,
    input  logic [`EX_INST_W-1:0] wb_inst,
    input  logic                  eq,
    input  logic                  lt,
    input  logic                  br_taken,
    ex_ctrl_if.ctrl               ctrl,
    output logic                  br_mispred,
    output logic                  br_suc
);

    rv_isa_pkg::opcode_e    opcode;
    logic [2:0]             funct3;
    logic [`EX_REG_W-1:0]   rs1;
    logic [`EX_REG_W-1:0]   rs2;
    logic [`EX_REG_W-1:0]   mem_rd;
    logic [`EX_REG_W-1:0]   wb_rd;
    logic                   mem_wr;
    logic                   wb_wr;
    logic                   is_branch;
    logic                   is_jump;
    logic                   cond;
    logic                   actual;

    assign opcode = rv_isa_pkg::opcode_e'(inst[6:2]);
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    always_comb begin
        ctrl.asel   = ex_ctrl_pkg::A_REG;
        ctrl.bsel   = ex_ctrl_pkg::B_REG;
        ctrl.alusel = ex_ctrl_pkg::ALU_ADD;
        ctrl.brun   = 1'b0;
        case (opcode)
            rv_isa_pkg::OP_RTYPE, rv_isa_pkg::OP_ITYPE: begin
                if (opcode == rv_isa_pkg::OP_ITYPE) begin
                    ctrl.bsel = ex_ctrl_pkg::B_IMM;
                end
                case (funct3)
                    rv_isa_pkg::F3_ADD_SUB: begin
                        // No SUBI, bit 30 is immediate data there
                        if (inst[30] && opcode == rv_isa_pkg::OP_RTYPE) begin
                            ctrl.alusel = ex_ctrl_pkg::ALU_SUB;
                        end
                    end
                    rv_isa_pkg::F3_SLL: ctrl.alusel = ex_ctrl_pkg::ALU_SLL;
                    rv_isa_pkg::F3_SLT: ctrl.alusel = ex_ctrl_pkg::ALU_SLT;
                    rv_isa_pkg::F3_SLTU: begin
                        ctrl.alusel = ex_ctrl_pkg::ALU_SLT;
                        ctrl.brun   = 1'b1;
                    end
                    rv_isa_pkg::F3_XOR: ctrl.alusel = ex_ctrl_pkg::ALU_XOR;
                    rv_isa_pkg::F3_SRL_SRA: begin
                        ctrl.alusel = inst[30] ? ex_ctrl_pkg::ALU_SRA : ex_ctrl_pkg::ALU_SRL;
                    end
                    rv_isa_pkg::F3_OR:  ctrl.alusel = ex_ctrl_pkg::ALU_OR;
                    default:            ctrl.alusel = ex_ctrl_pkg::ALU_AND;
                endcase
            end
            rv_isa_pkg::OP_LOAD, rv_isa_pkg::OP_STORE, rv_isa_pkg::OP_JALR: begin
                ctrl.bsel = ex_ctrl_pkg::B_IMM;
            end
            rv_isa_pkg::OP_BRANCH: begin
                ctrl.asel = ex_ctrl_pkg::A_PC;
                ctrl.bsel = ex_ctrl_pkg::B_IMM;
                // BLTU and BGEU
                ctrl.brun = funct3[1];
            end
            rv_isa_pkg::OP_JAL, rv_isa_pkg::OP_AUIPC: begin
                ctrl.asel = ex_ctrl_pkg::A_PC;
                ctrl.bsel = ex_ctrl_pkg::B_IMM;
            end
            rv_isa_pkg::OP_LUI: begin
                ctrl.bsel   = ex_ctrl_pkg::B_IMM;
                ctrl.alusel = ex_ctrl_pkg::ALU_PASS_B;
            end
            default: begin
                ctrl.asel = ex_ctrl_pkg::A_REG;
            end
        endcase
    end

    // Bypass only from instructions that really write a nonzero rd
    assign mem_rd = mem_inst[11:7];
    assign wb_rd  = wb_inst[11:7];
    assign mem_wr = rv_isa_pkg::writes_rd(rv_isa_pkg::opcode_e'(mem_inst[6:2]))
                    && mem_rd != `EX_REG_ZERO;
    assign wb_wr  = rv_isa_pkg::writes_rd(rv_isa_pkg::opcode_e'(wb_inst[6:2]))
                    && wb_rd != `EX_REG_ZERO;

    assign ctrl.fwda = (mem_wr && mem_rd == rs1) ? ex_ctrl_pkg::FWD_MEM :
                       (wb_wr && wb_rd == rs1)   ? ex_ctrl_pkg::FWD_WB  :
                                                   ex_ctrl_pkg::FWD_NONE;
    assign ctrl.fwdb = (mem_wr && mem_rd == rs2) ? ex_ctrl_pkg::FWD_MEM :
                       (wb_wr && wb_rd == rs2)   ? ex_ctrl_pkg::FWD_WB  :
                                                   ex_ctrl_pkg::FWD_NONE;

    // CSRRxI variants take zimm
    assign ctrl.csren   = opcode == rv_isa_pkg::OP_SYSTEM && funct3 != rv_isa_pkg::F3_PRIV;
    assign ctrl.csrwsel = funct3[2];

    always_comb begin
        case (funct3)
            rv_isa_pkg::F3_BEQ:                      cond = eq;
            rv_isa_pkg::F3_BNE:                      cond = ~eq;
            rv_isa_pkg::F3_BLT, rv_isa_pkg::F3_BLTU: cond = lt;
            rv_isa_pkg::F3_BGE, rv_isa_pkg::F3_BGEU: cond = ~lt;
            default:                                 cond = 1'b0;
        endcase
    end

    assign is_branch = opcode == rv_isa_pkg::OP_BRANCH;
    assign is_jump   = opcode == rv_isa_pkg::OP_JAL || opcode == rv_isa_pkg::OP_JALR;
    assign actual    = is_jump | (is_branch & cond);

    assign br_mispred = (is_branch | is_jump) && actual != br_taken;
    assign br_suc     = is_branch && actual == br_taken;

endmodule

`default_nettype wire

// ==== verilog/imm_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ex_defs.svh"

module imm_gen (
    input  logic [`EX_INST_W-1:0] inst,
    output logic [`EX_XLEN-1:0]   imm,
    output logic [`EX_XLEN-1:0]   zimm
);

    rv_isa_pkg::opcode_e opcode;

    assign opcode = rv_isa_pkg::opcode_e'(inst[6:2]);

    always_comb begin
        case (opcode)
            rv_isa_pkg::OP_STORE: begin
                imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
            end
            rv_isa_pkg::OP_BRANCH: begin
                imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_AUIPC: begin
                imm = {inst[31:12], 12'b0};
            end
            rv_isa_pkg::OP_JAL: begin
                imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                // I format, also shamt for shift immediates
                imm = {{21{inst[31]}}, inst[30:20]};
            end
        endcase
    end

    // CSR immediate sits in the rs1 field
    assign zimm = {{(`EX_XLEN-`EX_REG_W){1'b0}}, inst[19:15]};

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ex_defs.svh"

module alu (
    input  logic [`EX_XLEN-1:0] a,
    input  logic [`EX_XLEN-1:0] b,
    ex_ctrl_if.dp               ctrl,
    output logic [`EX_XLEN-1:0] result
);

    logic [4:0] shamt;
    logic       less;

    assign shamt = b[4:0];

    // brun selects SLTU/SLTIU
    assign less = ctrl.brun ? (a < b) : ($signed(a) < $signed(b));

    always_comb begin
        case (ctrl.alusel)
            ex_ctrl_pkg::ALU_ADD:    result = a + b;
            ex_ctrl_pkg::ALU_SUB:    result = a - b;
            ex_ctrl_pkg::ALU_AND:    result = a & b;
            ex_ctrl_pkg::ALU_OR:     result = a | b;
            ex_ctrl_pkg::ALU_XOR:    result = a ^ b;
            ex_ctrl_pkg::ALU_SLL:    result = a << shamt;
            ex_ctrl_pkg::ALU_SRL:    result = a >> shamt;
            ex_ctrl_pkg::ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
            ex_ctrl_pkg::ALU_SLT: begin
                result = {{(`EX_XLEN-1){1'b0}}, less};
            end
            // LUI
            ex_ctrl_pkg::ALU_PASS_B: result = b;
            default:                 result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/branch_comp.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ex_defs.svh"

module branch_comp (
    input  logic [`EX_XLEN-1:0] rs1_val,
    input  logic [`EX_XLEN-1:0] rs2_val,
    ex_ctrl_if.dp               ctrl,
    output logic                eq,
    output logic                lt
);

    logic lt_signed;
    logic lt_unsigned;

    assign eq = rs1_val == rs2_val;

    assign lt_signed   = $signed(rs1_val) < $signed(rs2_val);
    assign lt_unsigned = rs1_val < rs2_val;

    // BLTU/BGEU compare unsigned
    assign lt = ctrl.brun ? lt_unsigned : lt_signed;

endmodule

`default_nettype wire

// ==== verilog/ex_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ex_defs.svh"

module ex_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  logic [`EX_INST_W-1:0] inst,
    input  logic [`EX_XLEN-1:0]   pc,
    input  logic [`EX_XLEN-1:0]   rs1_data,
    input  logic [`EX_XLEN-1:0]   rs2_data,
    input  logic [`EX_INST_W-1:0] mem_inst,
    input  logic [`EX_XLEN-1:0]   mem_result,
    input  logic [`EX_INST_W-1:0] wb_inst,
    input  logic [`EX_XLEN-1:0]   wb_result,
    input  logic                  br_taken,
    output logic                  out_valid,
    output logic [`EX_XLEN-1:0]   alu_result,
    output logic [`EX_XLEN-1:0]   target,
    output logic                  redirect,
    output logic                  mispred,
    output logic                  br_suc,
    output logic                  csr_we,
    output logic [`EX_XLEN-1:0]   csr_wdata
);

    logic [`EX_XLEN-1:0] rs1_fwd;
    logic [`EX_XLEN-1:0] rs2_fwd;
    logic [`EX_XLEN-1:0] op_a;
    logic [`EX_XLEN-1:0] op_b;
    logic [`EX_XLEN-1:0] imm;
    logic [`EX_XLEN-1:0] zimm;
    logic [`EX_XLEN-1:0] alu_out;
    logic [`EX_XLEN-1:0] pc_plus4;
    logic [`EX_XLEN-1:0] jump_target;
    logic [`EX_XLEN-1:0] target_next;
    logic                eq;
    logic                lt;
    logic                br_mispred;
    logic                br_hit;
    logic                is_jalr;

    ex_ctrl_if ctrl ();

    ex_control u_control (
        .inst       (inst),
        .mem_inst   (mem_inst),
        .wb_inst    (wb_inst),
        .eq         (eq),
        .lt         (lt),
        .br_taken   (br_taken),
        .ctrl       (ctrl.ctrl),
        .br_mispred (br_mispred),
        .br_suc     (br_hit)
    );

    imm_gen u_imm_gen (
        .inst (inst),
        .imm  (imm),
        .zimm (zimm)
    );

    // Bypass muxes
    always_comb begin
        case (ctrl.fwda)
            ex_ctrl_pkg::FWD_MEM: rs1_fwd = mem_result;
            ex_ctrl_pkg::FWD_WB:  rs1_fwd = wb_result;
            default:              rs1_fwd = rs1_data;
        endcase
        case (ctrl.fwdb)
            ex_ctrl_pkg::FWD_MEM: rs2_fwd = mem_result;
            ex_ctrl_pkg::FWD_WB:  rs2_fwd = wb_result;
            default:              rs2_fwd = rs2_data;
        endcase
    end

    assign op_a = (ctrl.asel == ex_ctrl_pkg::A_PC)  ? pc  : rs1_fwd;
    assign op_b = (ctrl.bsel == ex_ctrl_pkg::B_IMM) ? imm : rs2_fwd;

    alu u_alu (
        .a      (op_a),
        .b      (op_b),
        .ctrl   (ctrl.dp),
        .result (alu_out)
    );

    branch_comp u_branch_comp (
        .rs1_val (rs1_fwd),
        .rs2_val (rs2_fwd),
        .ctrl    (ctrl.dp),
        .eq      (eq),
        .lt      (lt)
    );

    assign is_jalr     = rv_isa_pkg::opcode_e'(inst[6:2]) == rv_isa_pkg::OP_JALR;
    assign pc_plus4    = pc + `EX_XLEN'(4);
    assign jump_target = is_jalr ? {alu_out[`EX_XLEN-1:1], 1'b0} : alu_out;

    // Predicted taken but falls through, so resume at pc+4
    assign target_next = (br_mispred && br_taken) ? pc_plus4 : jump_target;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            redirect  <= 1'b0;
            mispred   <= 1'b0;
            br_suc    <= 1'b0;
            csr_we    <= 1'b0;
        end else begin
            out_valid <= in_valid;
            redirect  <= in_valid & br_mispred;
            mispred   <= in_valid & br_mispred;
            br_suc    <= in_valid & br_hit;
            csr_we    <= in_valid & ctrl.csren;
        end
    end

    always_ff @(posedge clk) begin
        alu_result <= alu_out;
        target     <= target_next;
        csr_wdata  <= ctrl.csrwsel ? zimm : rs1_fwd;
    end

endmodule

`default_nettype wire

// ==== verification/ex_stage_model.svh ====
`ifndef EX_STAGE_MODEL_SVH
`define EX_STAGE_MODEL_SVH

// One expected result per driven cycle
typedef struct packed {
    logic        valid;
    logic        chk_alu;
    logic        chk_target;
    logic [31:0] alu;
    logic [31:0] target;
    logic        redirect;
    logic        mispred;
    logic        br_suc;
    logic        csr_we;
    logic [31:0] csr_wdata;
} expect_t;

logic [31:0] lfsr_state = 32'h502d_b8fb;

// Taps x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int k = 0; k < n; k++) begin
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        bits = {bits[30:0], fb};
    end
    return bits;
endfunction

// Opcodes that leave a value in rd
function automatic logic has_dest(input logic [31:0] i);
    case (i[6:2])
        rv_isa_pkg::OP_RTYPE, rv_isa_pkg::OP_ITYPE, rv_isa_pkg::OP_LOAD,
        rv_isa_pkg::OP_JAL, rv_isa_pkg::OP_JALR, rv_isa_pkg::OP_LUI,
        rv_isa_pkg::OP_AUIPC, rv_isa_pkg::OP_SYSTEM: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

// Youngest writer wins, x0 never bypassed
function automatic logic [31:0] operand(input logic [4:0] idx, input logic [31:0] reg_val,
                                        input logic [31:0] mi, input logic [31:0] mr,
                                        input logic [31:0] wi, input logic [31:0] wr);
    if (idx != 5'd0 && has_dest(mi) && mi[11:7] == idx) begin
        return mr;
    end
    if (idx != 5'd0 && has_dest(wi) && wi[11:7] == idx) begin
        return wr;
    end
    return reg_val;
endfunction

function automatic logic [31:0] imm_of(input logic [31:0] i);
    case (i[6:2])
        rv_isa_pkg::OP_STORE:  return {{20{i[31]}}, i[31:25], i[11:7]};
        rv_isa_pkg::OP_BRANCH: return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
        rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_AUIPC: return {i[31:12], 12'h000};
        rv_isa_pkg::OP_JAL: return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
        default: return {{20{i[31]}}, i[31:20]};
    endcase
endfunction

function automatic expect_t predict(input logic v, input logic [31:0] i, input logic [31:0] pc,
                                    input logic [31:0] r1, input logic [31:0] r2,
                                    input logic [31:0] mi, input logic [31:0] mr,
                                    input logic [31:0] wi, input logic [31:0] wr,
                                    input logic taken);
    expect_t     e;
    logic [4:0]  op;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic        is_br;
    logic        is_jmp;
    logic        lt;
    logic        take;
    e = '0;
    op = i[6:2];
    f3 = i[14:12];
    a = operand(i[19:15], r1, mi, mr, wi, wr);
    b = operand(i[24:20], r2, mi, mr, wi, wr);
    imm = imm_of(i);
    is_br = op == rv_isa_pkg::OP_BRANCH;
    is_jmp = op == rv_isa_pkg::OP_JAL || op == rv_isa_pkg::OP_JALR;
    case (op)
        rv_isa_pkg::OP_RTYPE, rv_isa_pkg::OP_ITYPE: begin
            if (op == rv_isa_pkg::OP_ITYPE) begin
                b = imm;
            end
            case (f3)
                3'b000: e.alu = (op == rv_isa_pkg::OP_RTYPE && i[30]) ? a - b : a + b;
                3'b001: e.alu = a << b[4:0];
                3'b010: e.alu = {31'b0, $signed(a) < $signed(b)};
                3'b011: e.alu = {31'b0, a < b};
                3'b100: e.alu = a ^ b;
                3'b101: begin
                    if (i[30]) begin
                        e.alu = $signed(a) >>> b[4:0];
                    end else begin
                        e.alu = a >> b[4:0];
                    end
                end
                3'b110: e.alu = a | b;
                default: e.alu = a & b;
            endcase
        end
        rv_isa_pkg::OP_LUI: e.alu = imm;
        rv_isa_pkg::OP_AUIPC, rv_isa_pkg::OP_JAL, rv_isa_pkg::OP_BRANCH: e.alu = pc + imm;
        default: e.alu = a + imm;
    endcase
    // Branch outcome from the bypassed register values
    lt = f3[1] ? (a < b) : ($signed(a) < $signed(b));
    case (f3)
        3'b000: take = a == b;
        3'b001: take = a != b;
        3'b100, 3'b110: take = lt;
        default: take = !lt;
    endcase
    take = is_jmp | (is_br & take);
    if (is_br && !take && taken) begin
        e.target = pc + 32'd4;
    end else if (op == rv_isa_pkg::OP_JALR) begin
        e.target = (a + imm) & ~32'd1;
    end else begin
        e.target = pc + imm;
    end
    e.valid = v;
    e.chk_alu = v && op != rv_isa_pkg::OP_SYSTEM;
    e.chk_target = v && (is_br || is_jmp);
    e.mispred = v && (is_br || is_jmp) && take != taken;
    e.redirect = e.mispred;
    e.br_suc = v && is_br && take == taken;
    e.csr_we = v && op == rv_isa_pkg::OP_SYSTEM && f3 != 3'b000;
    e.csr_wdata = f3[2] ? {27'b0, i[19:15]} : a;
    return e;
endfunction

`endif

// ==== verification/ex_stage_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ex_defs.svh"

module ex_stage_tb;

    `include "ex_stage_model.svh"

    localparam int  NUM_INSTR   = 2000;
    localparam time CLK_PERIOD  = 8;
    localparam time WATCHDOG_NS = (NUM_INSTR + 10) * CLK_PERIOD + 200;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    logic [`EX_INST_W-1:0] inst;
    logic [`EX_XLEN-1:0]   pc;
    logic [`EX_XLEN-1:0]   rs1_data;
    logic [`EX_XLEN-1:0]   rs2_data;
    logic [`EX_INST_W-1:0] mem_inst;
    logic [`EX_XLEN-1:0]   mem_result;
    logic [`EX_INST_W-1:0] wb_inst;
    logic [`EX_XLEN-1:0]   wb_result;
    logic                  br_taken;
    logic                  out_valid;
    logic [`EX_XLEN-1:0]   alu_result;
    logic [`EX_XLEN-1:0]   target;
    logic                  redirect;
    logic                  mispred;
    logic                  br_suc;
    logic                  csr_we;
    logic [`EX_XLEN-1:0]   csr_wdata;

    expect_t exp_q[$];

    ex_stage dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .inst       (inst),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .mem_inst   (mem_inst),
        .mem_result (mem_result),
        .wb_inst    (wb_inst),
        .wb_result  (wb_result),
        .br_taken   (br_taken),
        .out_valid  (out_valid),
        .alu_result (alu_result),
        .target     (target),
        .redirect   (redirect),
        .mispred    (mispred),
        .br_suc     (br_suc),
        .csr_we     (csr_we),
        .csr_wdata  (csr_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t, stimulus loop never finished", $time);
        $display("Regression failed");
        $fatal(1, "watchdog timeout");
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t: %s = %h, expected %h", $time, name, got, exp);
            $display("Regression failed");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic check_outputs(input expect_t e);
        check_value("out_valid", 32'(out_valid), 32'(e.valid));
        check_value("redirect", 32'(redirect), 32'(e.redirect));
        check_value("mispred", 32'(mispred), 32'(e.mispred));
        check_value("br_suc", 32'(br_suc), 32'(e.br_suc));
        check_value("csr_we", 32'(csr_we), 32'(e.csr_we));
        if (e.chk_alu) begin
            check_value("alu_result", alu_result, e.alu);
        end
        if (e.chk_target) begin
            check_value("target", target, e.target);
        end
        if (e.csr_we) begin
            check_value("csr_wdata", csr_wdata, e.csr_wdata);
        end
    endtask

    // Legal RV32I encodings, registers x0..x7 so hazards are frequent
    function automatic logic [31:0] random_inst();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [2:0]  k;
        logic [31:0] r;
        rd = 5'(rand_bits(3));
        rs1 = 5'(rand_bits(3));
        rs2 = 5'(rand_bits(3));
        f3 = 3'(rand_bits(3));
        r = rand_bits(32);
        case (rand_bits(4))
            0, 1: begin
                if (f3 != 3'b000 && f3 != 3'b101) begin
                    r[30] = 1'b0;
                end
                return {1'b0, r[30], 5'b0, rs2, rs1, f3, rd, 7'b0110011};
            end
            4: begin
                k = 3'(rand_bits(3) % 5);
                f3 = (k > 3'd2) ? k + 3'd1 : k;
                return {r[31:20], rs1, f3, rd, 7'b0000011};
            end
            5: begin
                f3 = 3'(rand_bits(2) % 3);
                return {r[31:25], rs2, rs1, f3, r[11:7], 7'b0100011};
            end
            6, 7, 8: begin
                k = 3'(rand_bits(3) % 6);
                f3 = (k < 3'd2) ? k : k + 3'd2;
                return {r[31:25], rs2, rs1, f3, r[11:8], r[7], 7'b1100011};
            end
            9:  return {r[31:12], rd, 7'b1101111};
            10: return {r[31:20], rs1, 3'b000, rd, 7'b1100111};
            11: return {r[31:12], rd, 7'b0110111};
            12: return {r[31:12], rd, 7'b0010111};
            13, 14: begin
                k = 3'(rand_bits(3) % 6);
                f3 = (k < 3'd3) ? k + 3'd1 : k + 3'd2;
                return {r[31:20], rs1, f3, rd, 7'b1110011};
            end
            default: begin
                // Shift immediates keep funct7 legal
                if (f3 == 3'b001) begin
                    r[31:25] = 7'b0;
                end else if (f3 == 3'b101) begin
                    r[31:25] = {1'b0, r[30], 5'b0};
                end
                return {r[31:20], rs1, f3, rd, 7'b0010011};
            end
        endcase
    endfunction

    task automatic drive_random();
        in_valid = rand_bits(3) != 0;
        inst = random_inst();
        mem_inst = random_inst();
        wb_inst = random_inst();
        pc = rand_bits(30) << 2;
        rs1_data = rand_bits(32);
        rs2_data = (rand_bits(2) == 0) ? rs1_data : rand_bits(32);
        mem_result = rand_bits(32);
        wb_result = rand_bits(32);
        br_taken = 1'(rand_bits(1));
        exp_q.push_back(predict(in_valid, inst, pc, rs1_data, rs2_data,
                                mem_inst, mem_result, wb_inst, wb_result, br_taken));
    endtask

    initial begin
        rst_n = 1'b0;
        in_valid = 1'b0;
        inst = 32'h0000_0013;
        pc = '0;
        rs1_data = '0;
        rs2_data = '0;
        mem_inst = 32'h0000_0013;
        mem_result = '0;
        wb_inst = 32'h0000_0013;
        wb_result = '0;
        br_taken = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_outputs('0);
        rst_n = 1'b1;
        for (int n = 0; n < NUM_INSTR; n++) begin
            drive_random();
            @(negedge clk);
            check_outputs(exp_q.pop_front());
        end
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== ex_stage.f ====
+incdir+verilog
+incdir+verification
verilog/rv_isa_pkg.sv
verilog/ex_ctrl_pkg.sv
verilog/ex_ctrl_if.sv
verilog/ex_control.sv
verilog/imm_gen.sv
verilog/alu.sv
verilog/branch_comp.sv
verilog/ex_stage.sv
verification/ex_stage_tb.sv

// ==== Makefile ====
# Verilator build and run of the EX stage testbench

TOP := ex_stage_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module $(TOP) -f ex_stage.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
